//--- sim.f
rtl/ex_isa_pkg.sv
rtl/ex_pipe_pkg.sv
rtl/ex_regfile.sv
rtl/ex_bypass.sv
rtl/ex_alu.sv
rtl/ex_branch.sv
rtl/ex_mul.sv
rtl/ex_stage.sv
dv/ex_checker.sv
dv/tb_ex_stage.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_ex_stage -f sim.f -o tb_ex_stage

out=$(./obj_dir/tb_ex_stage)
echo "$out"

if echo "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

//--- dv/tb_ex_stage.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ex_stage
    import ex_isa_pkg::*;
    import ex_pipe_pkg::*;
();

    localparam int          CLK_PERIOD = 100;
    localparam int          N_PAIRS    = 400;
    localparam logic [31:0] SEED       = 32'd40;
    localparam int          WD_CYCLES  = N_PAIRS * 3 + 50;

    logic            clk;
    logic            rst;
    issue_t          issue0;
    issue_t          issue1;
    logic            stall;
    slot_t           wb0;
    slot_t           wb1;
    redirect_t       redirect;
    logic            exp_stall;

    // architectural model state
    logic [XLEN-1:0]  regs_m [0:31];
    logic [31:0]      lfsr;
    logic [XLEN-1:0]  pc_gen;
    logic             mul_prev_v;
    logic [REG_W-1:0] mul_prev_rd;
    logic             squash_next;

    always #(CLK_PERIOD / 2) clk = ~clk;

    ex_stage UUT (
        .clk      (clk),
        .rst      (rst),
        .issue0   (issue0),
        .issue1   (issue1),
        .stall    (stall),
        .wb0      (wb0),
        .wb1      (wb1),
        .redirect (redirect)
    );

    ex_checker u_chk (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .exp_stall (exp_stall),
        .wb0       (wb0),
        .wb1       (wb1),
        .redirect  (redirect)
    );

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [XLEN-1:0] alu_result(
        input alu_op_e         op,
        input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] b,
        input logic [XLEN-1:0] imm
    );
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_nor:  return ~(a | b);
            alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sltu: return (a < b) ? 32'd1 : 32'd0;
            alu_sll:  return a << b[4:0];
            alu_srl:  return a >> b[4:0];
            alu_sra:  return $unsigned($signed(a) >>> b[4:0]);
            alu_lui:  return imm;
            default:  return '0;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] mul_result(
        input mul_op_e         op,
        input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] b
    );
        logic signed [63:0] sp;
        logic [63:0]        up;
        sp = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        up = {32'd0, a} * {32'd0, b};
        case (op)
            mulh:    return sp[63:32];
            mulhu:   return up[63:32];
            default: return up[31:0];
        endcase
    endfunction

    function automatic logic branch_taken(
        input br_op_e          op,
        input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] b
    );
        case (op)
            br_beq:  return a == b;
            br_bne:  return a != b;
            br_blt:  return $signed(a) < $signed(b);
            br_bge:  return $signed(a) >= $signed(b);
            br_bltu: return a < b;
            br_bgeu: return a >= b;
            default: return 1'b1;
        endcase
    endfunction

    // rk is a source unless an alu op takes the immediate
    function automatic logic reads_reg(input issue_t ins, input logic [REG_W-1:0] r);
        logic rk_read;
        rk_read = !(ins.unit == unit_alu && ins.use_imm);
        return ins.valid && r != '0 && (ins.rj == r || (rk_read && ins.rk == r));
    endfunction

    task automatic write_model(input logic [REG_W-1:0] rd, input logic [XLEN-1:0] val);
        if (rd != '0) begin
            regs_m[rd] = val;
        end
    endtask

    // random word, or one of the sign corner values
    task automatic pick_imm(output logic [XLEN-1:0] imm);
        logic [31:0] v;
        rand_bits(2, v);
        case (v[1:0])
            2'd0:    rand_bits(32, imm);
            2'd1:    imm = 32'h8000_0000;
            2'd2:    imm = 32'hffff_ffff;
            default: rand_bits(5, imm);
        endcase
    endtask

    task automatic fill_alu(inout issue_t ins);
        logic [31:0] v;
        ins.unit = unit_alu;
        rand_bits(4, v);
        ins.alu_op = alu_op_e'(v[3:0] % 4'd12);
        rand_bits(1, v);
        ins.use_imm = v[0] || ins.alu_op == alu_lui;
        pick_imm(ins.imm);
        if (ins.alu_op == alu_lui) begin
            ins.rj = '0;
        end
    endtask

    task automatic make_pair(output issue_t i0, output issue_t i1);
        logic [31:0] v;
        i0 = '0;
        i1 = '0;
        rand_bits(4, v);
        i0.valid = (v[3:0] != 4'd0);
        i0.pc = pc_gen;
        i0.pc_next = pc_gen + 32'd4;
        rand_bits(3, v);
        i0.rd = {2'b00, v[2:0]};
        rand_bits(3, v);
        i0.rj = {2'b00, v[2:0]};
        rand_bits(3, v);
        i0.rk = {2'b00, v[2:0]};
        rand_bits(2, v);
        if (v[1] == 1'b0) begin
            fill_alu(i0);
        end else if (v[0] == 1'b0) begin
            i0.unit = unit_mul;
            rand_bits(2, v);
            i0.mul_op = mul_op_e'((v[1:0] == 2'd3) ? 2'd0 : v[1:0]);
        end else begin
            i0.unit = unit_br;
            rand_bits(3, v);
            i0.br_op = br_op_e'(v[2:0]);
            rand_bits(6, v);
            i0.imm = {{24{v[5]}}, v[5:0], 2'b00};
            rand_bits(1, v);
            i0.pc_next = v[0] ? pc_gen + i0.imm : pc_gen + 32'd4;
            if (i0.br_op == br_b || i0.br_op == br_bl) begin
                i0.rj = '0;
                i0.rk = '0;
            end
        end
        rand_bits(3, v);
        i1.valid = (v[2:0] != 3'd0);
        i1.pc = pc_gen + 32'd4;
        i1.pc_next = pc_gen + 32'd8;
        rand_bits(3, v);
        i1.rd = {2'b00, v[2:0]};
        rand_bits(3, v);
        i1.rj = {2'b00, v[2:0]};
        rand_bits(3, v);
        i1.rk = {2'b00, v[2:0]};
        fill_alu(i1);
        // lane 1 never reads lane 0's result of the same pair
        if (i1.rj == i0.rd) begin
            i1.rj = '0;
        end
        if (i1.rk == i0.rd) begin
            i1.rk = '0;
        end
        pc_gen = pc_gen + 32'd8;
    endtask

    // program order, lane 0 first
    task automatic execute_pair(input issue_t i0, input issue_t i1);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] res;
        logic [XLEN-1:0] next_pc;
        logic            misp;
        misp = 1'b0;
        if (i0.valid) begin
            a = regs_m[i0.rj];
            b = regs_m[i0.rk];
            case (i0.unit)
                unit_alu: begin
                    res = alu_result(i0.alu_op, a, i0.use_imm ? i0.imm : b, i0.imm);
                    u_chk.expect_wb(i0.rd, res, $sformatf("%s lane0", i0.alu_op.name()));
                    write_model(i0.rd, res);
                end
                unit_mul: begin
                    res = mul_result(i0.mul_op, a, b);
                    u_chk.expect_wb(i0.rd, res, i0.mul_op.name());
                    write_model(i0.rd, res);
                    mul_prev_v = 1'b1;
                    mul_prev_rd = i0.rd;
                end
                default: begin
                    next_pc = branch_taken(i0.br_op, a, b) ? i0.pc + i0.imm : i0.pc + 32'd4;
                    if (i0.br_op == br_bl) begin
                        u_chk.expect_wb(i0.rd, i0.pc + 32'd4, "br_bl link");
                        write_model(i0.rd, i0.pc + 32'd4);
                    end
                    if (next_pc != i0.pc_next) begin
                        misp = 1'b1;
                        u_chk.expect_redirect(next_pc, $sformatf("%s flush", i0.br_op.name()));
                    end
                end
            endcase
        end
        if (i1.valid && !misp) begin
            a = regs_m[i1.rj];
            b = regs_m[i1.rk];
            res = alu_result(i1.alu_op, a, i1.use_imm ? i1.imm : b, i1.imm);
            u_chk.expect_wb(i1.rd, res, $sformatf("%s lane1", i1.alu_op.name()));
            write_model(i1.rd, res);
        end
        squash_next = misp;
    endtask

    initial begin
        issue_t p0;
        issue_t p1;
        int     done_pairs;
        int     gen_pairs;
        logic   offered;
        clk = 1'b0;
        rst = 1'b1;
        issue0 = '0;
        issue1 = '0;
        exp_stall = 1'b0;
        lfsr = SEED;
        pc_gen = 32'h1c00_0000;
        mul_prev_v = 1'b0;
        mul_prev_rd = '0;
        squash_next = 1'b0;
        for (int i = 0; i < 32; i++) begin
            regs_m[i] = '0;
        end
        done_pairs = 0;
        gen_pairs = 0;
        offered = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        while (done_pairs < N_PAIRS) begin
            mul_prev_v = 1'b0;
            if (offered) begin
                if (squash_next) begin
                    // offered during flush, dropped
                    squash_next = 1'b0;
                    offered = 1'b0;
                    done_pairs++;
                end else if (!exp_stall) begin
                    // stall seen by the checker in the cycle that just ended
                    execute_pair(p0, p1);
                    offered = 1'b0;
                    done_pairs++;
                end
            end
            if (!offered && gen_pairs < N_PAIRS) begin
                make_pair(p0, p1);
                gen_pairs++;
                offered = 1'b1;
            end
            if (offered) begin
                issue0 <= p0;
                issue1 <= p1;
            end else begin
                issue0 <= '0;
                issue1 <= '0;
            end
            exp_stall <= offered && !squash_next && mul_prev_v &&
                         (reads_reg(p0, mul_prev_rd) || reads_reg(p1, mul_prev_rd));
            @(posedge clk);
        end
        while (u_chk.pending() != 0) begin
            @(posedge clk);
        end
        // catch any stray strobe after the last result
        repeat (4) @(posedge clk);
        u_chk.report_leftovers();
        $display("errors: %0d mismatches, %0d protocol", u_chk.mismatches, u_chk.protocol_errs);
        if (u_chk.mismatches + u_chk.protocol_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(WD_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", WD_CYCLES);
        u_chk.report_leftovers();
        $display("errors: %0d mismatches, %0d protocol", u_chk.mismatches, u_chk.protocol_errs);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/ex_checker.sv
`timescale 1ns/10ps
`default_nettype none

module ex_checker
    import ex_isa_pkg::*;
    import ex_pipe_pkg::*;
(
    input wire            clk,
    input wire            rst,
    input wire            stall,
    input wire            exp_stall,
    input wire slot_t     wb0,
    input wire slot_t     wb1,
    input wire redirect_t redirect
);

    slot_t           wb_q [$];
    string           wb_name_q [$];
    logic [XLEN-1:0] pc_q [$];
    string           pc_name_q [$];
    int              mismatches = 0;
    int              protocol_errs = 0;

    task automatic expect_wb(
        input logic [REG_W-1:0] rd,
        input logic [XLEN-1:0]  data,
        input string            name
    );
        slot_t s;
        s.valid = 1'b1;
        s.rd = rd;
        s.data = data;
        wb_q.push_back(s);
        wb_name_q.push_back(name);
    endtask

    task automatic expect_redirect(input logic [XLEN-1:0] pc, input string name);
        pc_q.push_back(pc);
        pc_name_q.push_back(name);
    endtask

    function automatic int pending();
        return wb_q.size() + pc_q.size();
    endfunction

    task automatic check_wb(input slot_t act, input string port);
        slot_t exp_slot;
        string name;
        if (wb_q.size() == 0) begin
            $display("%s wrote r%0d = %h when no writeback was expected", port, act.rd, act.data);
            protocol_errs++;
        end else begin
            exp_slot = wb_q.pop_front();
            name = wb_name_q.pop_front();
            if (exp_slot.rd !== act.rd || exp_slot.data !== act.data) begin
                $display("FAIL %s on %s: expected r%0d = %h, actual r%0d = %h",
                         name, port, exp_slot.rd, exp_slot.data, act.rd, act.data);
                mismatches++;
            end
        end
    endtask

    task automatic check_flush(input logic [XLEN-1:0] pc);
        logic [XLEN-1:0] exp_pc;
        string           name;
        if (pc_q.size() == 0) begin
            $display("flush raised with pc %h but no mispredict was expected", pc);
            protocol_errs++;
        end else begin
            exp_pc = pc_q.pop_front();
            name = pc_name_q.pop_front();
            if (exp_pc !== pc) begin
                $display("FAIL %s: expected pc %h, actual pc %h", name, exp_pc, pc);
                mismatches++;
            end
        end
    endtask

    task automatic report_leftovers();
        if (wb_q.size() != 0) begin
            $display("%0d expected writebacks never appeared", wb_q.size());
            protocol_errs += wb_q.size();
        end
        if (pc_q.size() != 0) begin
            $display("%0d expected flushes never appeared", pc_q.size());
            protocol_errs += pc_q.size();
        end
    endtask

    // pre-edge values, wb0 is older than wb1
    always @(posedge clk) begin
        if (!rst) begin
            if (wb0.valid) begin
                check_wb(wb0, "wb0");
            end
            if (wb1.valid) begin
                check_wb(wb1, "wb1");
            end
            if (redirect.flush) begin
                check_flush(redirect.pc);
            end
            if (stall !== exp_stall) begin
                $display("FAIL stall: expected %b, actual %b", exp_stall, stall);
                mismatches++;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/ex_stage.sv
`timescale 1ns/10ps
`default_nettype none

module ex_stage
    import ex_isa_pkg::*;
    import ex_pipe_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire issue_t issue0,
    input  wire issue_t issue1,
    output logic        stall,
    output slot_t       wb0,
    output slot_t       wb1,
    output redirect_t   redirect
);

    logic [XLEN-1:0] rf0;
    logic [XLEN-1:0] rf1;
    logic [XLEN-1:0] rf2;
    logic [XLEN-1:0] rf3;
    logic [XLEN-1:0] opa0;
    logic [XLEN-1:0] opb0;
    logic [XLEN-1:0] opa1;
    logic [XLEN-1:0] opb1;
    logic [XLEN-1:0] alu_res0;
    logic [XLEN-1:0] alu_res1;
    logic [XLEN-1:0] link;
    logic [XLEN-1:0] br_target;
    logic            br_misp;
    logic            mul_hazard;
    logic            accept;
    issue_t          mul_ins;
    mul_mid_t        mul_pend;
    slot_t           mul_out;
    slot_t           mid0;
    slot_t           mid1;
    slot_t           mid0_next;
    slot_t           mid1_next;
    slot_t           wb0_next;
    slot_t           wb1_next;

    ex_regfile u_regfile (
        .clk    (clk),
        .rst    (rst),
        .raddr0 (issue0.rj),
        .raddr1 (issue0.rk),
        .raddr2 (issue1.rj),
        .raddr3 (issue1.rk),
        .rdata0 (rf0),
        .rdata1 (rf1),
        .rdata2 (rf2),
        .rdata3 (rf3),
        .w0     (wb0),
        .w1     (wb1)
    );

    ex_bypass u_bypass (
        .issue0     (issue0),
        .issue1     (issue1),
        .rf0        (rf0),
        .rf1        (rf1),
        .rf2        (rf2),
        .rf3        (rf3),
        .mid0       (mid0),
        .mid1       (mid1),
        .mul_pend   (mul_pend),
        .wb0        (wb0),
        .wb1        (wb1),
        .opa0       (opa0),
        .opb0       (opb0),
        .opa1       (opa1),
        .opb1       (opb1),
        .mul_hazard (mul_hazard)
    );

    ex_alu u_alu0 (
        .ins    (issue0),
        .opa    (opa0),
        .opb    (opb0),
        .result (alu_res0)
    );

    ex_alu u_alu1 (
        .ins    (issue1),
        .opa    (opa1),
        .opb    (opb1),
        .result (alu_res1)
    );

    ex_branch u_branch (
        .ins        (issue0),
        .opa        (opa0),
        .opb        (opb0),
        .link       (link),
        .mispredict (br_misp),
        .target     (br_target)
    );

    ex_mul u_mul (
        .clk  (clk),
        .rst  (rst),
        .ins  (mul_ins),
        .opa  (opa0),
        .opb  (opb0),
        .pend (mul_pend),
        .out  (mul_out)
    );

    // a pair offered during flush is dropped but looks consumed
    assign stall  = mul_hazard & ~redirect.flush;
    assign accept = ~mul_hazard & ~redirect.flush;

    always_comb begin
        mul_ins       = issue0;
        mul_ins.valid = accept && issue0.valid;

        mid0_next.valid = accept && issue0.valid &&
                          (issue0.unit == unit_alu ||
                           (issue0.unit == unit_br && issue0.br_op == br_bl));
        mid0_next.rd    = issue0.rd;
        mid0_next.data  = (issue0.unit == unit_br) ? link : alu_res0;

        mid1_next.valid = accept && issue1.valid && issue1.unit == unit_alu;
        mid1_next.rd    = issue1.rd;
        mid1_next.data  = alu_res1;

        // lane 0 carries either an alu/link result or a product, never both
        wb0_next = mid0.valid ? mid0 : mul_out;

        // branch partner is squashed on flush
        wb1_next       = mid1;
        wb1_next.valid = mid1.valid && !redirect.flush;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mid0.valid     <= 1'b0;
            mid1.valid     <= 1'b0;
            wb0.valid      <= 1'b0;
            wb1.valid      <= 1'b0;
            redirect.flush <= 1'b0;
        end else begin
            mid0           <= mid0_next;
            mid1           <= mid1_next;
            wb0            <= wb0_next;
            wb1            <= wb1_next;
            redirect.flush <= accept && br_misp;
            redirect.pc    <= br_target;
        end
    end

endmodule

`default_nettype wire

//--- rtl/ex_mul.sv
`timescale 1ns/10ps
`default_nettype none

module ex_mul
    import ex_isa_pkg::*;
    import ex_pipe_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire  issue_t    ins,
    input  wire  [XLEN-1:0] opa,
    input  wire  [XLEN-1:0] opb,
    output mul_mid_t        pend,
    output slot_t           out
);

    logic               sgn;
    logic signed [16:0] ah;
    logic signed [16:0] al;
    logic signed [16:0] bh;
    logic signed [16:0] bl;
    logic signed [33:0] pp_hh;
    logic signed [33:0] pp_hl;
    logic signed [33:0] pp_lh;
    logic signed [33:0] pp_ll;

    // stage 1: only the upper halves carry a sign
    assign sgn = (ins.mul_op == mulh);
    assign ah  = {sgn & opa[31], opa[31:16]};
    assign al  = {1'b0, opa[15:0]};
    assign bh  = {sgn & opb[31], opb[31:16]};
    assign bl  = {1'b0, opb[15:0]};

    assign pp_hh = ah * bh;
    assign pp_hl = ah * bl;
    assign pp_lh = al * bh;
    assign pp_ll = al * bl;

    // every partial product fits in one word
    always_ff @(posedge clk) begin
        if (rst) begin
            pend.valid <= 1'b0;
        end else begin
            pend.valid  <= ins.valid && ins.unit == unit_mul;
            pend.rd     <= ins.rd;
            pend.mul_op <= ins.mul_op;
            pend.hh     <= pp_hh[XLEN-1:0];
            pend.hl     <= pp_hl[XLEN-1:0];
            pend.lh     <= pp_lh[XLEN-1:0];
            pend.ll     <= pp_ll[XLEN-1:0];
        end
    end

    // stage 2
    logic          sx;
    logic [63:0]   hh_x;
    logic [63:0]   hl_x;
    logic [63:0]   lh_x;
    logic [63:0]   prod;

    assign sx   = (pend.mul_op == mulh);
    assign hh_x = {{32{sx & pend.hh[31]}}, pend.hh};
    assign hl_x = {{32{sx & pend.hl[31]}}, pend.hl};
    assign lh_x = {{32{sx & pend.lh[31]}}, pend.lh};

    // ll is always unsigned
    assign prod = (hh_x << 32) + (hl_x << 16) + (lh_x << 16) + {32'd0, pend.ll};

    always_comb begin
        out.valid = pend.valid;
        out.rd    = pend.rd;
        out.data  = (pend.mul_op == mul_lo) ? prod[31:0] : prod[63:32];
    end

endmodule

`default_nettype wire

//--- rtl/ex_branch.sv
`timescale 1ns/10ps
`default_nettype none

module ex_branch
    import ex_isa_pkg::*;
(
    input  wire  issue_t    ins,
    input  wire  [XLEN-1:0] opa,
    input  wire  [XLEN-1:0] opb,
    output logic [XLEN-1:0] link,
    output logic            mispredict,
    output logic [XLEN-1:0] target
);

    logic taken;

    always_comb begin
        case (ins.br_op)
            br_beq: begin
                taken = (opa == opb);
            end
            br_bne: begin
                taken = (opa != opb);
            end
            br_blt: begin
                taken = ($signed(opa) < $signed(opb));
            end
            br_bge: begin
                taken = ($signed(opa) >= $signed(opb));
            end
            br_bltu: begin
                taken = (opa < opb);
            end
            br_bgeu: begin
                taken = (opa >= opb);
            end
            br_b, br_bl: begin
                taken = 1'b1;
            end
            default: begin
                taken = 1'b0;
            end
        endcase
    end

    // fall-through pc doubles as the link value
    assign link = ins.pc + XLEN'(4);

    // actual next pc, taken or not
    assign target = taken ? ins.pc + ins.imm : link;

    assign mispredict = ins.valid && ins.unit == unit_br && target != ins.pc_next;

endmodule

`default_nettype wire

//--- rtl/ex_alu.sv
`timescale 1ns/10ps
`default_nettype none

module ex_alu
    import ex_isa_pkg::*;
(
    input  wire  issue_t    ins,
    input  wire  [XLEN-1:0] opa,
    input  wire  [XLEN-1:0] opb,
    output logic [XLEN-1:0] result
);

    logic [XLEN-1:0] b_val;
    logic [4:0]      shamt;

    assign b_val = ins.use_imm ? ins.imm : opb;
    assign shamt = b_val[4:0];

    always_comb begin
        case (ins.alu_op)
            alu_add: begin
                result = opa + b_val;
            end
            alu_sub: begin
                result = opa - b_val;
            end
            alu_and: begin
                result = opa & b_val;
            end
            alu_or: begin
                result = opa | b_val;
            end
            alu_xor: begin
                result = opa ^ b_val;
            end
            alu_nor: begin
                result = ~(opa | b_val);
            end
            alu_slt: begin
                result = {{(XLEN-1){1'b0}}, $signed(opa) < $signed(b_val)};
            end
            alu_sltu: begin
                result = {{(XLEN-1){1'b0}}, opa < b_val};
            end
            alu_sll: begin
                result = opa << shamt;
            end
            alu_srl: begin
                result = opa >> shamt;
            end
            alu_sra: begin
                result = $unsigned($signed(opa) >>> shamt);
            end
            alu_lui: begin
                result = ins.imm;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/ex_bypass.sv
`timescale 1ns/10ps
`default_nettype none

module ex_bypass
    import ex_isa_pkg::*;
    import ex_pipe_pkg::*;
(
    input  wire  issue_t    issue0,
    input  wire  issue_t    issue1,
    input  wire  [XLEN-1:0] rf0,
    input  wire  [XLEN-1:0] rf1,
    input  wire  [XLEN-1:0] rf2,
    input  wire  [XLEN-1:0] rf3,
    input  wire  slot_t     mid0,
    input  wire  slot_t     mid1,
    input  wire  mul_mid_t  mul_pend,
    input  wire  slot_t     wb0,
    input  wire  slot_t     wb1,
    output logic [XLEN-1:0] opa0,
    output logic [XLEN-1:0] opb0,
    output logic [XLEN-1:0] opa1,
    output logic [XLEN-1:0] opb1,
    output logic            mul_hazard
);

    // youngest producer first
    function automatic logic [XLEN-1:0] fwd(
        input logic [REG_W-1:0] src,
        input logic [XLEN-1:0]  rf_val,
        input slot_t            m1,
        input slot_t            m0,
        input slot_t            w1,
        input slot_t            w0
    );
        logic [XLEN-1:0] val;
        val = rf_val;
        if (src != '0) begin
            if (m1.valid && m1.rd == src) begin
                val = m1.data;
            end else if (m0.valid && m0.rd == src) begin
                val = m0.data;
            end else if (w1.valid && w1.rd == src) begin
                val = w1.data;
            end else if (w0.valid && w0.rd == src) begin
                val = w0.data;
            end
        end
        return val;
    endfunction

    // rk is read unless an alu op takes imm instead
    function automatic logic reads_reg(input issue_t ins, input logic [REG_W-1:0] r);
        logic rk_used;
        rk_used = !ins.use_imm || ins.unit != unit_alu;
        return ins.valid && r != '0 && (ins.rj == r || (rk_used && ins.rk == r));
    endfunction

    assign opa0 = fwd(issue0.rj, rf0, mid1, mid0, wb1, wb0);
    assign opb0 = fwd(issue0.rk, rf1, mid1, mid0, wb1, wb0);
    assign opa1 = fwd(issue1.rj, rf2, mid1, mid0, wb1, wb0);
    assign opb1 = fwd(issue1.rk, rf3, mid1, mid0, wb1, wb0);

    // product only exists once it reaches writeback
    assign mul_hazard = mul_pend.valid &&
                        (reads_reg(issue0, mul_pend.rd) || reads_reg(issue1, mul_pend.rd));

endmodule

`default_nettype wire

//--- rtl/ex_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module ex_regfile
    import ex_isa_pkg::*;
    import ex_pipe_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    input  wire  [REG_W-1:0] raddr0,
    input  wire  [REG_W-1:0] raddr1,
    input  wire  [REG_W-1:0] raddr2,
    input  wire  [REG_W-1:0] raddr3,
    output logic [XLEN-1:0]  rdata0,
    output logic [XLEN-1:0]  rdata1,
    output logic [XLEN-1:0]  rdata2,
    output logic [XLEN-1:0]  rdata3,
    input  wire  slot_t      w0,
    input  wire  slot_t      w1
);

    logic [XLEN-1:0] regs [1:31];

    // r0 reads as zero
    assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];
    assign rdata3 = (raddr3 == '0) ? '0 : regs[raddr3];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (w0.valid && w0.rd != '0) begin
                regs[w0.rd] <= w0.data;
            end
            // younger lane last so it wins on the same rd
            if (w1.valid && w1.rd != '0) begin
                regs[w1.rd] <= w1.data;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/ex_pipe_pkg.sv
`default_nettype none

package ex_pipe_pkg;

    import ex_isa_pkg::*;

    // one result on its way to the register file
    typedef struct packed {
        logic             valid;
        logic [REG_W-1:0] rd;
        logic [XLEN-1:0]  data;
    } slot_t;

    // multiplier state between its two halves
    typedef struct packed {
        logic             valid;
        logic [REG_W-1:0] rd;
        mul_op_e          mul_op;
        logic [XLEN-1:0]  hh;
        logic [XLEN-1:0]  hl;
        logic [XLEN-1:0]  lh;
        logic [XLEN-1:0]  ll;
    } mul_mid_t;

    typedef struct packed {
        logic            flush;
        logic [XLEN-1:0] pc;
    } redirect_t;

endpackage

`default_nettype wire

//--- rtl/ex_isa_pkg.sv
`default_nettype none

package ex_isa_pkg;

    localparam int XLEN  = 32;
    localparam int REG_W = 5;

    typedef enum logic [1:0] {
        unit_alu = 2'd0,
        unit_mul = 2'd1,
        unit_br  = 2'd2
    } unit_e;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_nor  = 4'd5,
        alu_slt  = 4'd6,
        alu_sltu = 4'd7,
        alu_sll  = 4'd8,
        alu_srl  = 4'd9,
        alu_sra  = 4'd10,
        // passes imm straight through
        alu_lui  = 4'd11
    } alu_op_e;

    typedef enum logic [1:0] {
        mul_lo = 2'd0,
        mulh   = 2'd1,
        mulhu  = 2'd2
    } mul_op_e;

    typedef enum logic [2:0] {
        br_beq  = 3'd0,
        br_bne  = 3'd1,
        br_blt  = 3'd2,
        br_bge  = 3'd3,
        br_bltu = 3'd4,
        br_bgeu = 3'd5,
        br_b    = 3'd6,
        // links pc+4 into rd
        br_bl   = 3'd7
    } br_op_e;

    typedef struct packed {
        logic             valid;
        unit_e            unit;
        alu_op_e          alu_op;
        mul_op_e          mul_op;
        br_op_e           br_op;
        logic             use_imm;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rj;
        logic [REG_W-1:0] rk;
        logic [XLEN-1:0]  imm;
        logic [XLEN-1:0]  pc;
        // predicted next pc from fetch
        logic [XLEN-1:0]  pc_next;
    } issue_t;

endpackage

`default_nettype wire
